//--- compile.f
+incdir+.
mmio_pkg.sv
mmio_cmd_fifo.sv
mmio_axil_master.sv
mmio_reg_slave.sv
mmio_subsystem_top.sv
mmio_tb.sv

//--- mmio_axil_master.sv
// AXI-lite master that drains the command queue in order.
// One command issues per cycle at most; a command waits at the head while
// its direction still has an address pending or is at the outstanding limit.
// rready and bready are tied high, so responses are never back-pressured.
// Results come back as one-cycle pulses, one cycle after rvalid or bvalid.

`timescale 1ns/1ns

`include "mmio_defs.svh"

module mmio_axil_master (
  input  logic                clk,
  input  logic                rst,

  // Queue head.
  input  mmio_pkg::mmio_cmd_t head,
  input  logic                empty,
  output logic                pop,

  // Read address.
  output logic                arvalid,
  input  logic                arready,
  output mmio_pkg::mmio_ar_t  ar,

  // Read data.
  input  logic                rvalid,
  output logic                rready,
  input  mmio_pkg::mmio_r_t   r,

  // Write address and data.
  output logic                awvalid,
  input  logic                awready,
  output mmio_pkg::mmio_aw_t  aw,
  output logic                wvalid,
  input  logic                wready,
  output mmio_pkg::mmio_w_t   w,

  // Write response.
  input  logic                bvalid,
  output logic                bready,
  input  mmio_pkg::mmio_b_t   b,

  // Host results.
  output logic                rd_rsp_valid,
  output mmio_pkg::mmio_rsp_t rd_rsp,
  output logic                wr_rsp_valid,
  output mmio_pkg::mmio_rsp_t wr_rsp
);

  // Counter must hold MAX_OUT itself.
  localparam int CNT_W = $clog2(`MMIO_MAX_OUT + 1);

  logic [CNT_W-1:0] rd_out;
  logic [CNT_W-1:0] wr_out;

  // Direction free to take a new command.
  logic rd_free;
  logic wr_free;

  // At most one issue strobe per cycle.
  logic issue_rd;
  logic issue_wr;

  // Channel handshakes.
  logic r_fire;
  logic b_fire;

  // Responses are always accepted.
  assign rready = 1'b1;
  assign bready = 1'b1;

  assign r_fire = rvalid && rready;
  assign b_fire = bvalid && bready;

  assign rd_free = !arvalid && (rd_out < CNT_W'(`MMIO_MAX_OUT));
  assign wr_free = !awvalid && !wvalid && (wr_out < CNT_W'(`MMIO_MAX_OUT));

  // Head pops only when its own direction is free.
  assign pop      = !empty && (head.wr ? wr_free : rd_free);
  assign issue_rd = pop && !head.wr;
  assign issue_wr = pop && head.wr;

  // Read address valid drops on its handshake.
  always_ff @(posedge clk) begin
    if (rst) begin
      arvalid <= 1'b0;
    end else if (issue_rd) begin
      arvalid <= 1'b1;
    end else if (arvalid && arready) begin
      arvalid <= 1'b0;
    end
  end

  // Write address and data go out together but may be taken separately.
  always_ff @(posedge clk) begin
    if (rst) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else if (issue_wr) begin
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
    end else begin
      if (awvalid && awready) begin
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
      end
    end
  end

  // Channel payloads hold until the next issue.
  always_ff @(posedge clk) begin
    if (issue_rd) begin
      ar.addr <= head.addr;
    end
    if (issue_wr) begin
      aw.addr <= head.addr;
      w.data  <= head.data;
    end
  end

  // Outstanding counts rise on issue and fall on response.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_out <= '0;
      wr_out <= '0;
    end else begin
      case ({issue_rd, r_fire})
        2'b10:   rd_out <= rd_out + 1'b1;
        2'b01:   rd_out <= rd_out - 1'b1;
        default: rd_out <= rd_out;
      endcase
      case ({issue_wr, b_fire})
        2'b10:   wr_out <= wr_out + 1'b1;
        2'b01:   wr_out <= wr_out - 1'b1;
        default: wr_out <= wr_out;
      endcase
    end
  end

  // Host pulses.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_rsp_valid <= 1'b0;
      wr_rsp_valid <= 1'b0;
    end else begin
      rd_rsp_valid <= r_fire;
      wr_rsp_valid <= b_fire;
    end
  end

  // Result payloads. Writes report zero data.
  always_ff @(posedge clk) begin
    if (r_fire) begin
      rd_rsp.data <= r.data;
      rd_rsp.resp <= r.resp;
    end
    if (b_fire) begin
      wr_rsp.data <= '0;
      wr_rsp.resp <= b.resp;
    end
  end

endmodule

//--- mmio_cmd_fifo.sv
// Circular command queue between the host and the AXI-lite master.
// A push while full is dropped, and a pop while empty is ignored.
// Head is read combinationally from storage.
// Push and pop may happen in the same cycle.

`timescale 1ns/1ns

`include "mmio_defs.svh"

module mmio_cmd_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  mmio_pkg::mmio_cmd_t push_cmd,
  input  logic                pop,
  output mmio_pkg::mmio_cmd_t head,
  output logic                empty,
  output logic                full
);

  // Pointers carry one extra wrap bit above the index.
  localparam int PTR_W = `MMIO_FIFO_AW + 1;

  // Command storage.
  mmio_pkg::mmio_cmd_t mem [`MMIO_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // Accepted push and pop for this cycle.
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Equal pointers mean empty.
  assign empty = (wr_ptr == rd_ptr);

  // Same index with opposite wrap bits means full.
  assign full = (wr_ptr[PTR_W-1] != rd_ptr[PTR_W-1]) &&
                (wr_ptr[PTR_W-2:0] == rd_ptr[PTR_W-2:0]);

  // Oldest entry.
  assign head = mem[rd_ptr[PTR_W-2:0]];

  // Pointer updates.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage write at the tail.
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[PTR_W-2:0]] <= push_cmd;
    end
  end

endmodule

//--- mmio_defs.svh
// Shared sizing and response codes for the MMIO command bridge.
// Queue depth must be a power of two; it is set through its log2.
// The register count must also be a power of two so that the word
// index is a plain bit slice of the byte address.
// Response codes follow the usual AXI encoding.

`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// Log2 of the command queue depth.
`define MMIO_FIFO_AW 2

// Command queue depth in entries.
`define MMIO_FIFO_DEPTH (1 << `MMIO_FIFO_AW)

// Number of 64-bit registers in the slave bank.
`define MMIO_REG_COUNT 16

// Requests allowed in flight per direction from issue to response.
`define MMIO_MAX_OUT 4

// OKAY response.
`define MMIO_RESP_OKAY 2'd0

// SLVERR response for misaligned or unmapped addresses.
`define MMIO_RESP_SLVERR 2'd2

`endif

//--- mmio_pkg.sv
// Types shared by the MMIO command bridge.
// Addresses are 32-bit byte addresses and data is one 64-bit word.
// Write strobes and protection bits are not carried.

`include "mmio_defs.svh"

package mmio_pkg;

  // Byte address on the AXI-lite channels.
  typedef logic [31:0] mmio_addr_t;

  // One register word.
  typedef logic [63:0] mmio_data_t;

  // AXI response code.
  typedef logic [1:0] mmio_resp_t;

  // Word index into the register bank.
  typedef logic [$clog2(`MMIO_REG_COUNT)-1:0] mmio_idx_t;

  // Host command as it sits in the queue.
  // Data is ignored for reads.
  typedef struct packed {
    logic       wr;
    mmio_addr_t addr;
    mmio_data_t data;
  } mmio_cmd_t;

  // Result of one request; data is zero for writes.
  typedef struct packed {
    mmio_data_t data;
    mmio_resp_t resp;
  } mmio_rsp_t;

  // Read-address channel payload.
  typedef struct packed {
    mmio_addr_t addr;
  } mmio_ar_t;

  // Write-address channel payload.
  typedef struct packed {
    mmio_addr_t addr;
  } mmio_aw_t;

  // Write-data channel payload.
  typedef struct packed {
    mmio_data_t data;
  } mmio_w_t;

  // Read-data channel payload.
  typedef struct packed {
    mmio_data_t data;
    mmio_resp_t resp;
  } mmio_r_t;

  // Write-response channel payload.
  typedef struct packed {
    mmio_resp_t resp;
  } mmio_b_t;

  // Slave channel state; RESP means the response register is full.
  typedef enum logic {
    IDLE = 1'b0,
    RESP = 1'b1
  } slave_state_e;

endpackage

//--- mmio_reg_slave.sv
// AXI-lite register bank of 64-bit words at 8-byte spacing from address 0.
// Misaligned or unmapped addresses get SLVERR; bad writes change nothing.
// awready and wready rise together and only when both valids are present.
// Each response is registered and held until taken.

`timescale 1ns/1ns

`include "mmio_defs.svh"

module mmio_reg_slave (
  input  logic               clk,
  input  logic               rst,

  // Read address.
  input  logic               arvalid,
  output logic               arready,
  input  mmio_pkg::mmio_ar_t ar,

  // Read data.
  output logic               rvalid,
  input  logic               rready,
  output mmio_pkg::mmio_r_t  r,

  // Write address and data.
  input  logic               awvalid,
  output logic               awready,
  input  mmio_pkg::mmio_aw_t aw,
  input  logic               wvalid,
  output logic               wready,
  input  mmio_pkg::mmio_w_t  w,

  // Write response.
  output logic               bvalid,
  input  logic               bready,
  output mmio_pkg::mmio_b_t  b
);

  // Width of the word index.
  localparam int IDX_W = $bits(mmio_pkg::mmio_idx_t);

  // Register storage.
  mmio_pkg::mmio_data_t regs [`MMIO_REG_COUNT];

  mmio_pkg::slave_state_e rd_state;
  mmio_pkg::slave_state_e wr_state;

  logic ar_fire;
  logic wr_fire;

  logic rd_ok;
  logic wr_ok;

  mmio_pkg::mmio_idx_t rd_idx;
  mmio_pkg::mmio_idx_t wr_idx;

  // Aligned and inside the bank.
  function automatic logic addr_ok(mmio_pkg::mmio_addr_t addr);
    return (addr[2:0] == 3'b000) && (addr[31:3] < 29'(`MMIO_REG_COUNT));
  endfunction

  assign rd_ok  = addr_ok(ar.addr);
  assign wr_ok  = addr_ok(aw.addr);
  assign rd_idx = ar.addr[3 +: IDX_W];
  assign wr_idx = aw.addr[3 +: IDX_W];

  // Valid mirrors a full response register.
  assign rvalid = (rd_state == mmio_pkg::RESP);
  assign bvalid = (wr_state == mmio_pkg::RESP);

  // Ready while the response register is empty or being drained.
  assign arready = !rvalid || rready;
  assign awready = awvalid && wvalid && (!bvalid || bready);
  assign wready  = awready;

  assign ar_fire = arvalid && arready;
  assign wr_fire = awvalid && awready;

  // Read channel state.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= mmio_pkg::IDLE;
    end else if (ar_fire) begin
      rd_state <= mmio_pkg::RESP;
    end else if (rvalid && rready) begin
      rd_state <= mmio_pkg::IDLE;
    end
  end

  // Write channel state.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= mmio_pkg::IDLE;
    end else if (wr_fire) begin
      wr_state <= mmio_pkg::RESP;
    end else if (bvalid && bready) begin
      wr_state <= mmio_pkg::IDLE;
    end
  end

  // Read response payload. Bad reads return zero data.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      r.data <= rd_ok ? regs[rd_idx] : '0;
      r.resp <= rd_ok ? `MMIO_RESP_OKAY : `MMIO_RESP_SLVERR;
    end
  end

  // Write response payload.
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b.resp <= wr_ok ? `MMIO_RESP_OKAY : `MMIO_RESP_SLVERR;
    end
  end

  // Register bank is cleared on reset and written at acceptance.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MMIO_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire && wr_ok) begin
      regs[wr_idx] <= w.data;
    end
  end

endmodule

//--- mmio_subsystem_top.sv
// MMIO command bridge: host queue, AXI-lite master and register bank.
// The host must not push while cmd_full is high; such pushes are dropped.
// Read and write results are one-cycle pulses and may coincide.

`timescale 1ns/1ns

module mmio_subsystem_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_push,
  input  mmio_pkg::mmio_cmd_t cmd,
  output logic                cmd_full,
  output logic                rd_rsp_valid,
  output mmio_pkg::mmio_rsp_t rd_rsp,
  output logic                wr_rsp_valid,
  output mmio_pkg::mmio_rsp_t wr_rsp
);

  // Queue to master.
  mmio_pkg::mmio_cmd_t head;
  logic                empty;
  logic                pop;

  // AXI-lite channels.
  logic                arvalid;
  logic                arready;
  mmio_pkg::mmio_ar_t  ar;
  logic                rvalid;
  logic                rready;
  mmio_pkg::mmio_r_t   r;
  logic                awvalid;
  logic                awready;
  mmio_pkg::mmio_aw_t  aw;
  logic                wvalid;
  logic                wready;
  mmio_pkg::mmio_w_t   w;
  logic                bvalid;
  logic                bready;
  mmio_pkg::mmio_b_t   b;

  mmio_cmd_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (cmd_push),
    .push_cmd (cmd),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .full     (cmd_full)
  );

  mmio_axil_master u_master (
    .clk          (clk),
    .rst          (rst),
    .head         (head),
    .empty        (empty),
    .pop          (pop),
    .arvalid      (arvalid),
    .arready      (arready),
    .ar           (ar),
    .rvalid       (rvalid),
    .rready       (rready),
    .r            (r),
    .awvalid      (awvalid),
    .awready      (awready),
    .aw           (aw),
    .wvalid       (wvalid),
    .wready       (wready),
    .w            (w),
    .bvalid       (bvalid),
    .bready       (bready),
    .b            (b),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp       (rd_rsp),
    .wr_rsp_valid (wr_rsp_valid),
    .wr_rsp       (wr_rsp)
  );

  mmio_reg_slave u_slave (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .arready (arready),
    .ar      (ar),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r),
    .awvalid (awvalid),
    .awready (awready),
    .aw      (aw),
    .wvalid  (wvalid),
    .wready  (wready),
    .w       (w),
    .bvalid  (bvalid),
    .bready  (bready),
    .b       (b)
  );

endmodule

//--- mmio_tb.sv
// Testbench for the MMIO command bridge top level.
// Stimulus comes from a 16-bit Galois LFSR; a shadow register model predicts
// every response. Inputs change on the rising edge and all checks run on the
// falling edge, where DUT outputs are stable.
// The queue fill level is tracked from pushes and the internal pop strobe.

`timescale 1ns/1ns

`include "mmio_defs.svh"

module mmio_tb;

  localparam int SEND_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;
  localparam int RANDOM_CMDS = 400;

  logic                clk;
  logic                rst;
  logic                cmd_push;
  mmio_pkg::mmio_cmd_t cmd;
  logic                cmd_full;
  logic                rd_rsp_valid;
  mmio_pkg::mmio_rsp_t rd_rsp;
  logic                wr_rsp_valid;
  mmio_pkg::mmio_rsp_t wr_rsp;

  // Shadow of the register bank.
  mmio_pkg::mmio_data_t shadow [`MMIO_REG_COUNT];

  // Expected responses, oldest first.
  mmio_pkg::mmio_rsp_t exp_rd [$];
  mmio_pkg::mmio_rsp_t exp_wr [$];
  mmio_pkg::mmio_rsp_t exp_now;

  logic [15:0] lfsr;

  // Queued entries after the most recent rising edge.
  int q_count = 0;
  int full_cycles = 0;

  mmio_subsystem_top dut (
    .clk          (clk),
    .rst          (rst),
    .cmd_push     (cmd_push),
    .cmd          (cmd),
    .cmd_full     (cmd_full),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp       (rd_rsp),
    .wr_rsp_valid (wr_rsp_valid),
    .wr_rsp       (wr_rsp)
  );

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string why);
    $display("ERROR at %0t: %s", $time, why);
    abort_run();
  endtask

  task automatic check_rsp(input string name, input mmio_pkg::mmio_rsp_t exp,
                           input mmio_pkg::mmio_rsp_t act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected data=%h resp=%0d actual data=%h resp=%0d",
               $time, name, exp.data, exp.resp, act.data, act.resp);
      abort_run();
    end
  endtask

  task automatic check_full(input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED time=%0t cmd_full expected=%b actual=%b", $time, exp, act);
      abort_run();
    end
  endtask

  // One LFSR step. The shifted-out bit is the random bit.
  function automatic logic take_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], take_bit()};
    end
    return v;
  endfunction

  // Reference model. Decodes, applies to the shadow and predicts the response.
  function automatic mmio_pkg::mmio_rsp_t model_apply(input mmio_pkg::mmio_cmd_t c);
    mmio_pkg::mmio_rsp_t rsp;
    logic                ok;
    logic [3:0]          idx;
    ok       = (c.addr[2:0] == 3'b000) && (c.addr[31:7] == 25'd0);
    idx      = c.addr[6:3];
    rsp.resp = ok ? `MMIO_RESP_OKAY : `MMIO_RESP_SLVERR;
    rsp.data = '0;
    if (c.wr) begin
      if (ok) begin
        shadow[idx] = c.data;
      end
    end else if (ok) begin
      rsp.data = shadow[idx];
    end
    return rsp;
  endfunction

  // Builds a command; a bad address is either misaligned or above the bank.
  function automatic mmio_pkg::mmio_cmd_t make_cmd(input logic wr, input logic [3:0] idx,
                                                   input logic bad,
                                                   input mmio_pkg::mmio_data_t data);
    mmio_pkg::mmio_cmd_t c;
    logic [63:0]         r;
    c.wr   = wr;
    c.data = data;
    c.addr = {25'd0, idx, 3'b000};
    if (bad) begin
      r = take_bits(6);
      if (r[5]) begin
        c.addr[2:0] = (r[2:0] == 3'b000) ? 3'b100 : r[2:0];
      end else begin
        c.addr = c.addr | (32'h80 << (r[4:0] % 5'd25));
      end
    end
    return c;
  endfunction

  // Pushes one command as soon as the queue has room.
  task automatic send_cmd(input mmio_pkg::mmio_cmd_t c);
    int                  waited;
    mmio_pkg::mmio_rsp_t exp;
    waited = 0;
    while (q_count >= `MMIO_FIFO_DEPTH) begin
      cmd_push <= 1'b0;
      @(posedge clk);
      waited++;
      if (waited > SEND_LIMIT) begin
        fail_plain("queue stayed full, a command could not be pushed");
      end
    end
    exp = model_apply(c);
    if (c.wr) begin
      exp_wr.push_back(exp);
    end else begin
      exp_rd.push_back(exp);
    end
    cmd_push <= 1'b1;
    cmd      <= c;
    @(posedge clk);
  endtask

  task automatic idle_cycle();
    cmd_push <= 1'b0;
    @(posedge clk);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    cmd_push <= 1'b0;
    while (exp_rd.size() != 0 || exp_wr.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > DRAIN_LIMIT) begin
        fail_plain("pushed commands did not all get a response in time");
      end
    end
  endtask

  // Compare process. Also tracks the queue level for the next edge.
  always @(negedge clk) begin
    if (rst) begin
      q_count = 0;
    end else begin
      check_full(q_count == `MMIO_FIFO_DEPTH, cmd_full);
      if (cmd_full) begin
        full_cycles++;
      end
      q_count = q_count + ((cmd_push && q_count < `MMIO_FIFO_DEPTH) ? 1 : 0)
                - (dut.pop ? 1 : 0);
      if (rd_rsp_valid === 1'b1) begin
        if (exp_rd.size() == 0) begin
          fail_plain("read response arrived with no read pending");
        end
        exp_now = exp_rd.pop_front();
        check_rsp("rd_rsp", exp_now, rd_rsp);
      end
      if (wr_rsp_valid === 1'b1) begin
        if (exp_wr.size() == 0) begin
          fail_plain("write response arrived with no write pending");
        end
        exp_now = exp_wr.pop_front();
        check_rsp("wr_rsp", exp_now, wr_rsp);
      end
    end
  end

  initial begin
    logic [63:0]          r;
    mmio_pkg::mmio_data_t data;
    int                   sent;
    int                   full_before;
    lfsr     = 16'd34133;
    rst      = 1'b1;
    cmd_push = 1'b0;
    cmd      = '0;
    for (int i = 0; i < `MMIO_REG_COUNT; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Registers read back zero after reset.
    for (int i = 0; i < `MMIO_REG_COUNT; i++) begin
      send_cmd(make_cmd(1'b0, 4'(i), 1'b0, '0));
    end
    wait_drain();

    // Write then read back random registers.
    for (int i = 0; i < 24; i++) begin
      r    = take_bits(4);
      data = take_bits(64);
      send_cmd(make_cmd(1'b1, r[3:0], 1'b0, data));
      send_cmd(make_cmd(1'b0, r[3:0], 1'b0, '0));
    end
    wait_drain();

    // Bad addresses, then a full sweep shows nothing changed.
    for (int i = 0; i < 12; i++) begin
      r    = take_bits(5);
      data = take_bits(64);
      send_cmd(make_cmd(r[4], r[3:0], 1'b1, data));
    end
    for (int i = 0; i < `MMIO_REG_COUNT; i++) begin
      send_cmd(make_cmd(1'b0, 4'(i), 1'b0, '0));
    end
    wait_drain();

    // Back-to-back burst must fill the queue.
    // The first half is all writes, which issue only every other cycle.
    full_before = full_cycles;
    for (int i = 0; i < 16; i++) begin
      r    = take_bits(5);
      data = take_bits(64);
      send_cmd(make_cmd((i < 8) ? 1'b1 : r[4], r[3:0], 1'b0, data));
    end
    wait_drain();
    if (full_cycles == full_before) begin
      fail_plain("queue never reported full during the burst");
    end

    // Long mixed run with random gaps and some bad addresses.
    sent = 0;
    while (sent < RANDOM_CMDS) begin
      r = take_bits(1);
      if (r[0]) begin
        r    = take_bits(8);
        data = take_bits(64);
        send_cmd(make_cmd(r[7], r[6:3], r[2:0] == 3'b111, data));
        sent++;
      end else begin
        idle_cycle();
      end
    end
    wait_drain();

    // Quiet cycles let a stray pulse still be caught.
    for (int i = 0; i < 8; i++) begin
      idle_cycle();
    end
    if (exp_rd.size() == 0 && exp_wr.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_plain("responses still pending at the end of the run");
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module mmio_tb -o mmio_sim

status=0
out=$(./obj_dir/mmio_sim 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Simulation passed$'; then
  exit 0
fi
echo "Run did not pass, simulator exit status $status"
exit 1
